// File: Makefile
# Verilator build and run of the audio control front end
# Any variable below can be overridden, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP       ?= audio_ctrl_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_STR  ?= Simulation finished: PASS
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run, and search the log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_STR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "$(PASS_STR)" $(LOG) || (echo "Test run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/audio_ctrl_tb.sv
`include "audio_macros.svh"

module audio_ctrl_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import audio_regs_pkg::*;

    localparam int HALF_CLKS     = 10;  // clk cycles per sclk half period
    localparam int DRV_DLY       = 2;
    localparam int STB_TIMEOUT   = 40;
    localparam int WATCHDOG_CLKS = 100000;

    logic                    clk;
    logic                    rst_n;
    logic                    spi_cs_n;
    logic                    spi_sclk;
    logic                    spi_mosi;
    wire                     spi_miso;
    logic [7:0]              status_in;
    logic [7:0]              mpio_rd_reg;
    logic [7:0]              sram_rd_reg;
    logic [7:0]              audio_control;
    logic [7:0]              aux_reg;
    logic [7:0]              test_reg;
    logic [7:0]              mpio_wr_reg;
    logic [7:0]              sram_wr_reg;
    logic                    coef_wr_stb;
    logic [FILTER_IDX_W-1:0] coef_rd_filter;
    logic [TAP_IDX_W-1:0]    coef_rd_tap;
    coef_t                   coef_rd_data;

    // Reference model of the register map
    logic [7:0]              exp_control;
    logic [7:0]              exp_aux;
    logic [7:0]              exp_test;
    logic [7:0]              exp_mpio;
    logic [7:0]              exp_sram;
    logic [7:0]              exp_lsb;
    logic [TAP_IDX_W-1:0]    exp_tap;
    logic [FILTER_IDX_W-1:0] exp_filter;
    logic [15:0]             coef_model [`AUD_NUM_FILTERS][`AUD_NUM_TAPS];
    int                      loaded_f[$];
    int                      loaded_t[$];
    logic                    model_valid;  // Low while a frame is in flight
    int                      exp_stb;
    int                      stb_seen;
    int                      errors;
    int                      tests_ok;
    int                      tests_bad;
    int                      seed;

    pullup (spi_miso);  // Released MISO reads high

    audio_ctrl_top dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .spi_cs_n       (spi_cs_n),
        .spi_sclk       (spi_sclk),
        .spi_mosi       (spi_mosi),
        .spi_miso       (spi_miso),
        .status_in      (status_in),
        .mpio_rd_reg    (mpio_rd_reg),
        .sram_rd_reg    (sram_rd_reg),
        .audio_control  (audio_control),
        .aux_reg        (aux_reg),
        .test_reg       (test_reg),
        .mpio_wr_reg    (mpio_wr_reg),
        .sram_wr_reg    (sram_wr_reg),
        .coef_wr_stb    (coef_wr_stb),
        .coef_rd_filter (coef_rd_filter),
        .coef_rd_tap    (coef_rd_tap),
        .coef_rd_data   (coef_rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        if (rst_n && coef_wr_stb) stb_seen++;
    end

    function automatic void flag_mismatch(string name, logic [15:0] exp, logic [15:0] got);
        errors++;
        $display("Mismatch %s exp %h got %h", name, exp, got);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Output checks against the model
    //////////////////////////////////////////////////////////////////////
    a_control: assert property (@(posedge clk) disable iff (!rst_n || !model_valid)
        audio_control == exp_control)
        else flag_mismatch("audio_control", 16'(exp_control), 16'(audio_control));
    a_aux: assert property (@(posedge clk) disable iff (!rst_n || !model_valid)
        aux_reg == exp_aux) else flag_mismatch("aux_reg", 16'(exp_aux), 16'(aux_reg));
    a_test: assert property (@(posedge clk) disable iff (!rst_n || !model_valid)
        test_reg == exp_test) else flag_mismatch("test_reg", 16'(exp_test), 16'(test_reg));
    a_mpio: assert property (@(posedge clk) disable iff (!rst_n || !model_valid)
        mpio_wr_reg == exp_mpio)
        else flag_mismatch("mpio_wr_reg", 16'(exp_mpio), 16'(mpio_wr_reg));
    a_sram: assert property (@(posedge clk) disable iff (!rst_n || !model_valid)
        sram_wr_reg == exp_sram)
        else flag_mismatch("sram_wr_reg", 16'(exp_sram), 16'(sram_wr_reg));
    a_stb_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        coef_wr_stb |=> !coef_wr_stb)
        else begin
            errors++;
            $display("coef_wr_stb stayed high for more than one cycle");
        end

    //////////////////////////////////////////////////////////////////////
    // SPI master, mode 0
    //////////////////////////////////////////////////////////////////////
    task automatic half_period();
        repeat (HALF_CLKS) @(posedge clk);
        #DRV_DLY;
    endtask

    // Shifts nbits of tx out MSB first, collects MISO over the data byte
    task automatic spi_frame(input logic [15:0] tx, input int nbits, output logic [7:0] rx);
        model_valid = 1'b0;
        rx = '0;
        spi_cs_n = 1'b0;
        for (int i = 0; i < nbits; i++) begin
            spi_mosi = tx[15-i];
            half_period();
            if (i >= 8) rx = {rx[6:0], spi_miso};
            spi_sclk = 1'b1;
            half_period();
            spi_sclk = 1'b0;
        end
        half_period();
        spi_cs_n = 1'b1;
        half_period();
    endtask

    task automatic model_write(input logic [6:0] addr, input logic [7:0] data);
        case (addr)
            AUD_CONTROL: exp_control = data;
            TAP_SEL:     exp_tap     = data[TAP_IDX_W-1:0];
            FILTER_SEL:  exp_filter  = data[FILTER_IDX_W-1:0];
            COEF_LSB:    exp_lsb     = data;
            COEF_MSB: begin
                coef_model[exp_filter][exp_tap] = {data, exp_lsb};
                loaded_f.push_back(int'(exp_filter));
                loaded_t.push_back(int'(exp_tap));
                exp_tap = TAP_IDX_W'((int'(exp_tap) + 1) % `AUD_NUM_TAPS);  // Wraps at 32
                exp_stb++;
            end
            MPIO:        exp_mpio    = data;
            SRAM:        exp_sram    = data;
            AUX:         exp_aux     = data;
            TEST:        exp_test    = data;
            default:     ;
        endcase
    endtask

    task automatic reg_write(input logic [6:0] addr, input logic [7:0] data);
        logic [7:0] unused;
        spi_frame({1'b0, addr, data}, 16, unused);
        model_write(addr, data);
        model_valid = 1'b1;
    endtask

    task automatic reg_read_check(input logic [6:0] addr, input logic [7:0] exp, input string name);
        logic [7:0] rx;
        spi_frame({1'b1, addr, 8'h00}, 16, rx);
        model_valid = 1'b1;
        assert (rx == exp) else flag_mismatch(name, 16'(exp), 16'(rx));
    endtask

    task automatic wait_coef_strobe();
        int t;
        t = 0;
        while (stb_seen < exp_stb && t < STB_TIMEOUT) begin
            @(posedge clk);
            t++;
        end
        #DRV_DLY;
        if (t == STB_TIMEOUT) begin
            errors++;
            $display("Timeout waiting for coef_wr_stb after a COEF_MSB write");
        end
        assert (stb_seen == exp_stb)
            else flag_mismatch("coef_wr_stb count", 16'(exp_stb), 16'(stb_seen));
    endtask

    task automatic load_coefs(input int count);
        logic [15:0] c;
        for (int i = 0; i < count; i++) begin
            c = 16'($random(seed));
            reg_write(COEF_LSB, c[7:0]);
            reg_write(COEF_MSB, c[15:8]);
            wait_coef_strobe();
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            tests_ok++;
            $display("Test %s: ok", name);
        end else begin
            tests_bad++;
            $display("Test %s: %0d errors", name, errors - errs_before);
        end
    endtask

    initial begin
        repeat (WATCHDOG_CLKS) @(posedge clk);
        $display("Watchdog expired before the tests completed");
        $display("Simulation finished: FAIL");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////
    initial begin
        int         mark;
        logic [7:0] unused;
        seed = 53;
        {errors, tests_ok, tests_bad, exp_stb, stb_seen} = '0;
        {spi_cs_n, spi_sclk, spi_mosi} = 3'b100;
        {status_in, mpio_rd_reg, sram_rd_reg} = '0;
        coef_rd_filter = '0;
        coef_rd_tap = '0;
        {exp_control, exp_aux, exp_test, exp_mpio, exp_sram, exp_lsb} = '0;
        exp_tap = '0;
        exp_filter = '0;
        model_valid = 1'b1;
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        #DRV_DLY;
        rst_n = 1'b1;

        mark = errors;
        repeat (20) @(posedge clk);
        #DRV_DLY;
        assert (spi_miso === 1'b1) else begin
            errors++;
            $display("MISO is driven while CS is high after reset");
        end
        assert (stb_seen == 0) else flag_mismatch("coef_wr_stb count", 16'd0, 16'(stb_seen));
        finish_test("reset state", mark);

        mark = errors;
        mpio_rd_reg = 8'($random(seed));
        sram_rd_reg = 8'($random(seed));
        reg_write(AUD_CONTROL, 8'($random(seed)));
        reg_write(AUX, 8'($random(seed)));
        reg_write(TEST, 8'($random(seed)));
        reg_write(MPIO, 8'($random(seed)));
        reg_write(SRAM, 8'($random(seed)));
        reg_read_check(AUD_CONTROL, exp_control, "rdata AUD_CONTROL");
        reg_read_check(AUX, exp_aux, "rdata AUX");
        reg_read_check(TEST, exp_test, "rdata TEST");
        reg_read_check(MPIO, mpio_rd_reg, "rdata MPIO");
        reg_read_check(SRAM, sram_rd_reg, "rdata SRAM");
        finish_test("register write and readback", mark);

        mark = errors;
        status_in = 8'($random(seed)) | 8'h01;  // Pin bit 0 must not reach the read
        reg_read_check(STATUS, {status_in[7:1], 1'b0}, "rdata STATUS");
        reg_read_check(7'h2a, 8'had, "rdata unmapped");
        finish_test("status and unmapped read", mark);

        mark = errors;
        reg_write(FILTER_SEL, 8'h01);
        reg_write(TAP_SEL, 8'h04);
        load_coefs(4);
        reg_read_check(TAP_SEL, 8'(exp_tap), "rdata TAP_SEL");
        reg_write(FILTER_SEL, 8'h02);
        reg_write(TAP_SEL, 8'd30);
        load_coefs(3);  // Taps 30, 31, then 0
        reg_read_check(TAP_SEL, 8'(exp_tap), "rdata TAP_SEL after wrap");
        finish_test("coefficient loading", mark);

        mark = errors;
        for (int i = 0; i < loaded_f.size(); i++) begin
            coef_rd_filter = FILTER_IDX_W'(loaded_f[i]);
            coef_rd_tap = TAP_IDX_W'(loaded_t[i]);
            @(posedge clk);
            #DRV_DLY;
            assert (coef_rd_data == coef_model[loaded_f[i]][loaded_t[i]])
                else flag_mismatch("coef_rd_data", coef_model[loaded_f[i]][loaded_t[i]],
                                   coef_rd_data);
        end
        for (int i = 0; i < loaded_f.size(); i++) begin
            reg_write(FILTER_SEL, 8'(loaded_f[i]));
            reg_write(TAP_SEL, 8'(loaded_t[i]));
            reg_read_check(COEF_LSB, coef_model[loaded_f[i]][loaded_t[i]][7:0], "rdata COEF_LSB");
            reg_read_check(COEF_MSB, coef_model[loaded_f[i]][loaded_t[i]][15:8], "rdata COEF_MSB");
        end
        finish_test("coefficient readback", mark);

        mark = errors;
        spi_frame({1'b0, AUX, ~exp_aux}, 10, unused);  // CS rises after 10 bits
        model_valid = 1'b1;
        reg_read_check(AUX, exp_aux, "rdata AUX after abort");
        finish_test("aborted frame", mark);

        $display("Tests passed %0d failed %0d, errors %0d", tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: design/audio_ctrl_top.sv
module audio_ctrl_top (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    spi_cs_n,
    input  logic                                    spi_sclk,
    input  logic                                    spi_mosi,
    output tri                                      spi_miso,
    input  logic [7:0]                              status_in,
    input  logic [7:0]                              mpio_rd_reg,
    input  logic [7:0]                              sram_rd_reg,
    output logic [7:0]                              audio_control,
    output logic [7:0]                              aux_reg,
    output logic [7:0]                              test_reg,
    output logic [7:0]                              mpio_wr_reg,
    output logic [7:0]                              sram_wr_reg,
    output logic                                    coef_wr_stb,
    input  logic [audio_regs_pkg::FILTER_IDX_W-1:0] coef_rd_filter,
    input  logic [audio_regs_pkg::TAP_IDX_W-1:0]    coef_rd_tap,
    output audio_regs_pkg::coef_t                   coef_rd_data
);
    import audio_regs_pkg::*;

    // Bank to store link
    logic                    coef_wr_req;
    logic                    coef_wr_ack;
    coef_wr_t                coef_wr;
    coef_t                   coef_host_data;
    logic [FILTER_IDX_W-1:0] coef_host_filter;
    logic [TAP_IDX_W-1:0]    coef_host_tap;

    audio_reg_bank bank0 (
        .clk              (clk),
        .rst_n            (rst_n),
        .spi_cs_n         (spi_cs_n),
        .spi_sclk         (spi_sclk),
        .spi_mosi         (spi_mosi),
        .spi_miso         (spi_miso),
        .status_in        (status_in),
        .audio_control    (audio_control),
        .aux_reg          (aux_reg),
        .test_reg         (test_reg),
        .mpio_wr_reg      (mpio_wr_reg),
        .sram_wr_reg      (sram_wr_reg),
        .mpio_rd_reg      (mpio_rd_reg),
        .sram_rd_reg      (sram_rd_reg),
        .coef_wr_stb      (coef_wr_stb),
        .coef_wr_req      (coef_wr_req),
        .coef_wr_ack      (coef_wr_ack),
        .coef_wr          (coef_wr),
        .coef_host_data   (coef_host_data),
        .coef_host_filter (coef_host_filter),
        .coef_host_tap    (coef_host_tap)
    );

    coef_store store0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_req      (coef_wr_req),
        .wr_ack      (coef_wr_ack),
        .wr          (coef_wr),
        .host_filter (coef_host_filter),
        .host_tap    (coef_host_tap),
        .host_data   (coef_host_data),
        .rd_filter   (coef_rd_filter),
        .rd_tap      (coef_rd_tap),
        .rd_data     (coef_rd_data)
    );

endmodule

// File: design/audio_macros.svh
`ifndef AUDIO_MACROS_SVH
`define AUDIO_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// Equalizer sizing
//////////////////////////////////////////////////////////////////////

// Independent FIR filters in the equalizer
`define AUD_NUM_FILTERS 4

// Taps per filter, also the wrap point of the tap index
`define AUD_NUM_TAPS 32

// Coefficient word, written as two bytes over SPI
`define AUD_COEF_W 16

`endif

// File: design/audio_reg_bank.sv
`include "audio_macros.svh"

module audio_reg_bank (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    spi_cs_n,
    input  logic                                    spi_sclk,
    input  logic                                    spi_mosi,
    output tri                                      spi_miso,
    input  logic [7:0]                              status_in,
    output logic [7:0]                              audio_control,
    output logic [7:0]                              aux_reg,
    output logic [7:0]                              test_reg,
    output logic [7:0]                              mpio_wr_reg,
    output logic [7:0]                              sram_wr_reg,
    input  logic [7:0]                              mpio_rd_reg,
    input  logic [7:0]                              sram_rd_reg,
    output logic                                    coef_wr_stb,
    output logic                                    coef_wr_req,
    input  logic                                    coef_wr_ack,
    output audio_regs_pkg::coef_wr_t                coef_wr,
    input  audio_regs_pkg::coef_t                   coef_host_data,
    output logic [audio_regs_pkg::FILTER_IDX_W-1:0] coef_host_filter,
    output logic [audio_regs_pkg::TAP_IDX_W-1:0]    coef_host_tap
);
    import audio_regs_pkg::*;

    reg_bus_if bus ();

    logic [TAP_IDX_W-1:0]    tap_sel;
    logic [FILTER_IDX_W-1:0] filter_sel;
    logic [7:0]              coef_lsb;
    logic                    coef_busy;
    logic                    access;  // Request taken this cycle
    logic                    msb_wr;
    logic [7:0]              rd_mux;

    spi_frame_slave slave0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .spi_cs_n (spi_cs_n),
        .spi_sclk (spi_sclk),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso),
        .bus      (bus.master)
    );

    assign coef_busy = coef_wr_req | coef_wr_ack;  // Open until store ack drops
    assign access    = bus.req && !bus.ack && !coef_busy;
    assign msb_wr    = access && bus.we && (bus.addr == COEF_MSB);

    assign coef_host_filter = filter_sel;
    assign coef_host_tap    = tap_sel;

    //////////////////////////////////////////////////////////////////////
    // Read decode
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        case (bus.addr)
            AUD_CONTROL: rd_mux = audio_control;
            STATUS:      rd_mux = {status_in[7:1], coef_busy};
            TAP_SEL:     rd_mux = 8'(tap_sel);
            FILTER_SEL:  rd_mux = 8'(filter_sel);
            COEF_LSB:    rd_mux = coef_host_data[7:0];
            COEF_MSB:    rd_mux = coef_host_data[15:8];
            MPIO:        rd_mux = mpio_rd_reg;
            SRAM:        rd_mux = sram_rd_reg;
            AUX:         rd_mux = aux_reg;
            TEST:        rd_mux = test_reg;
            default:     rd_mux = UNMAPPED_READ;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Register writes and handshakes
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            audio_control <= '0;
            aux_reg       <= '0;
            test_reg      <= '0;
            mpio_wr_reg   <= '0;
            sram_wr_reg   <= '0;
            tap_sel       <= '0;
            filter_sel    <= '0;
            coef_lsb      <= '0;
            coef_wr_req   <= 1'b0;
            coef_wr_stb   <= 1'b0;
            bus.ack       <= 1'b0;
        end else begin
            coef_wr_stb <= 1'b0;
            if (!bus.req && bus.ack) begin
                bus.ack <= 1'b0;
            end
            if (access && bus.we) begin
                case (bus.addr)
                    AUD_CONTROL: audio_control <= bus.wdata;
                    TAP_SEL:     tap_sel       <= bus.wdata[TAP_IDX_W-1:0];
                    FILTER_SEL:  filter_sel    <= bus.wdata[FILTER_IDX_W-1:0];
                    COEF_LSB:    coef_lsb      <= bus.wdata;
                    MPIO:        mpio_wr_reg   <= bus.wdata;
                    SRAM:        sram_wr_reg   <= bus.wdata;
                    AUX:         aux_reg       <= bus.wdata;
                    TEST:        test_reg      <= bus.wdata;
                    default:     ;
                endcase
            end
            if (msb_wr) begin
                coef_wr_req <= 1'b1;  // SPI ack held until the store accepts
            end else if (access) begin
                bus.ack <= 1'b1;
            end
            if (coef_wr_req && coef_wr_ack) begin
                coef_wr_req <= 1'b0;
                coef_wr_stb <= 1'b1;
                bus.ack     <= 1'b1;
                tap_sel     <= (tap_sel == TAP_IDX_W'(`AUD_NUM_TAPS - 1)) ? '0
                                                                      : tap_sel + 1'b1;
            end
        end
    end

    // Payloads
    always_ff @(posedge clk) begin
        if (access) begin
            bus.rdata <= rd_mux;
        end
        if (msb_wr) begin
            coef_wr.filter <= filter_sel;
            coef_wr.tap    <= tap_sel;
            coef_wr.coef   <= coef_t'({bus.wdata, coef_lsb});
        end
    end

    // Store request and its payload held until the store acks
    a_coef_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        coef_wr_req && !coef_wr_ack |=> coef_wr_req && $stable(coef_wr));

endmodule

// File: design/audio_regs_pkg.sv
`include "audio_macros.svh"

package audio_regs_pkg;

    // Index widths into the coefficient store
    localparam int FILTER_IDX_W = $clog2(`AUD_NUM_FILTERS);
    localparam int TAP_IDX_W    = $clog2(`AUD_NUM_TAPS);

    // Returned for reads of anything not in the map
    localparam logic [7:0] UNMAPPED_READ = 8'had;

    //////////////////////////////////////////////////////////////////////
    // Register map
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [6:0] {
        AUD_CONTROL = 7'h00,
        STATUS      = 7'h01,  // Read only
        TAP_SEL     = 7'h02,  // Auto-increments after each MSB write
        FILTER_SEL  = 7'h03,
        COEF_LSB    = 7'h04,
        COEF_MSB    = 7'h05,  // Write commits the coefficient
        MPIO        = 7'h06,
        SRAM        = 7'h07,
        AUX         = 7'h08,
        TEST        = 7'h09
    } reg_addr_e;

    typedef logic signed [`AUD_COEF_W-1:0] coef_t;

    // Payload of one coefficient write
    typedef struct packed {
        logic [FILTER_IDX_W-1:0] filter;
        logic [TAP_IDX_W-1:0]    tap;
        coef_t                   coef;
    } coef_wr_t;

endpackage

// File: design/coef_store.sv
`include "audio_macros.svh"

module coef_store (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    wr_req,
    output logic                                    wr_ack,
    input  audio_regs_pkg::coef_wr_t                wr,
    input  logic [audio_regs_pkg::FILTER_IDX_W-1:0] host_filter,
    input  logic [audio_regs_pkg::TAP_IDX_W-1:0]    host_tap,
    output audio_regs_pkg::coef_t                   host_data,
    input  logic [audio_regs_pkg::FILTER_IDX_W-1:0] rd_filter,
    input  logic [audio_regs_pkg::TAP_IDX_W-1:0]    rd_tap,
    output audio_regs_pkg::coef_t                   rd_data
);
    import audio_regs_pkg::*;

    coef_t mem [`AUD_NUM_FILTERS][`AUD_NUM_TAPS];
    logic  wr_en;

    assign wr_en = wr_req && !wr_ack;  // Rising phase of the handshake

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ack <= 1'b0;
        end else if (wr_en) begin
            wr_ack <= 1'b1;
        end else if (!wr_req) begin
            wr_ack <= 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Storage and read ports
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr.filter][wr.tap] <= wr.coef;
        end
        rd_data <= mem[rd_filter][rd_tap];  // Registered read for the filter datapath
    end

    // Host readback for the register bank
    assign host_data = mem[host_filter][host_tap];

    // Lone ack only right after a cycle with req and ack both high
    a_ack_phase: assert property (@(posedge clk) disable iff (!rst_n)
        wr_ack && !wr_req |-> $past(wr_req && wr_ack));

endmodule

// File: design/reg_bus_if.sv
// Four-phase register access link between SPI slave and register bank
interface reg_bus_if;
    import audio_regs_pkg::*;

    logic       req;
    logic       we;     // 1 = write, 0 = read
    reg_addr_e  addr;
    logic [7:0] wdata;
    logic [7:0] rdata;  // Valid with ack
    logic       ack;

    modport master (
        output req,
        output we,
        output addr,
        output wdata,
        input  rdata,
        input  ack
    );

    modport slave (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output rdata,
        output ack
    );

endinterface

// File: design/spi_frame_pkg.sv
package spi_frame_pkg;

    // One host transaction on the SPI link
    localparam int SPI_FRAME_BITS = 16;

    // Command view of a frame, first bit on the wire at the top
    typedef struct packed {
        logic       rd;    // 1 = register read
        logic [6:0] addr;  // Register address
        logic [7:0] data;  // Write byte, ignored on reads
    } spi_cmd_t;

    // Same word seen two ways
    typedef union packed {
        logic [SPI_FRAME_BITS-1:0] raw;  // Shift register view
        spi_cmd_t                  cmd;  // Decoded fields
    } spi_frame_t;

endpackage

// File: design/spi_frame_slave.sv
module spi_frame_slave (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      spi_cs_n,
    input  logic      spi_sclk,
    input  logic      spi_mosi,
    output tri        spi_miso,
    reg_bus_if.master bus
);
    import spi_frame_pkg::*;
    import audio_regs_pkg::*;

    localparam int HDR_BITS = 8;  // Read flag plus address
    localparam int CNT_W    = $clog2(SPI_FRAME_BITS + 1);

    logic [1:0]       cs_sync;
    logic [1:0]       sclk_sync;
    logic [1:0]       mosi_sync;
    logic             sclk_d;
    logic             sclk_rise;
    logic             sclk_fall;
    logic [CNT_W-1:0] bit_cnt;
    spi_frame_t       frame;
    spi_frame_t       frame_nxt;
    spi_frame_t       hdr_nxt;
    logic             rd_start;
    logic             wr_start;
    logic             ack_d;
    logic [7:0]       tx_shift;
    logic             miso_q;

    //////////////////////////////////////////////////////////////////////
    // Pin synchronizers and sclk edge detect
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cs_sync   <= 2'b11;  // Deselected
            sclk_sync <= 2'b00;
            mosi_sync <= 2'b00;
            sclk_d    <= 1'b0;
        end else begin
            cs_sync   <= {cs_sync[0], spi_cs_n};
            sclk_sync <= {sclk_sync[0], spi_sclk};
            mosi_sync <= {mosi_sync[0], spi_mosi};
            sclk_d    <= sclk_sync[1];
        end
    end

    assign sclk_rise = sclk_sync[1] & ~sclk_d & ~cs_sync[1];
    assign sclk_fall = ~sclk_sync[1] & sclk_d & ~cs_sync[1];

    // Frame as it will look after this bit, and the header left-aligned
    always_comb begin
        frame_nxt.raw = {frame.raw[SPI_FRAME_BITS-2:0], mosi_sync[1]};
        hdr_nxt.raw   = {frame_nxt.raw[HDR_BITS-1:0], {(SPI_FRAME_BITS-HDR_BITS){1'b0}}};
    end

    assign rd_start = sclk_rise && (bit_cnt == CNT_W'(HDR_BITS - 1)) && hdr_nxt.cmd.rd;
    assign wr_start = sclk_rise && (bit_cnt == CNT_W'(SPI_FRAME_BITS - 1))
                      && !frame_nxt.cmd.rd;

    //////////////////////////////////////////////////////////////////////
    // Bit counter and bus handshake
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt <= '0;
            bus.req <= 1'b0;
            ack_d   <= 1'b0;
            miso_q  <= 1'b0;
        end else begin
            ack_d <= bus.ack;
            if (cs_sync[1]) begin
                bit_cnt <= '0;  // Short frames are dropped here
            end else if (sclk_rise && bit_cnt != CNT_W'(SPI_FRAME_BITS)) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
            if (bus.req && bus.ack) begin
                bus.req <= 1'b0;
            end else if (rd_start || wr_start) begin
                bus.req <= 1'b1;
            end
            if (sclk_fall && bit_cnt >= CNT_W'(HDR_BITS)) begin
                miso_q <= tx_shift[7];
            end
        end
    end

    // Frame shifter and request fields
    always_ff @(posedge clk) begin
        if (sclk_rise) begin
            frame <= frame_nxt;
        end
        if (rd_start) begin
            bus.we   <= 1'b0;
            bus.addr <= reg_addr_e'(hdr_nxt.cmd.addr);
        end else if (wr_start) begin
            bus.we    <= 1'b1;
            bus.addr  <= reg_addr_e'(frame_nxt.cmd.addr);
            bus.wdata <= frame_nxt.cmd.data;
        end
    end

    // Read byte goes out MSB first, one bit per falling edge
    always_ff @(posedge clk) begin
        if (bus.ack && !ack_d && !bus.we) begin
            tx_shift <= bus.rdata;
        end else if (sclk_fall && bit_cnt >= CNT_W'(HDR_BITS)) begin
            tx_shift <= {tx_shift[6:0], 1'b0};
        end
    end

    assign spi_miso = spi_cs_n ? 1'bz : miso_q;

    // Previous handshake must close before a new request
    a_req_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
        !bus.req && bus.ack |=> !bus.req);

    a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        bus.req |=> !bus.req || $stable(bus.addr));

endmodule

// File: sim.f
+incdir+design
design/spi_frame_pkg.sv
design/audio_regs_pkg.sv
design/reg_bus_if.sv
design/spi_frame_slave.sv
design/audio_reg_bank.sv
design/coef_store.sv
design/audio_ctrl_top.sv
bench/audio_ctrl_tb.sv
